// ==== design/sqrt_pkg.sv ====
package sqrt_pkg;

    // axi4-lite field widths
    typedef logic [4:0]  axil_addr_t;  // byte address, 32 bytes of register space
    typedef logic [31:0] axil_data_t;  // bus word, also holds the operand
    typedef logic [1:0]  axil_resp_t;

    // response codes
    localparam axil_resp_t resp_okay   = 2'b00;
    localparam axil_resp_t resp_slverr = 2'b10;  // unmapped address

    // register map, word aligned
    localparam axil_addr_t reg_ctrl    = 5'h00;  // write only
    localparam axil_addr_t reg_status  = 5'h04;  // read only
    localparam axil_addr_t reg_operand = 5'h08;  // read / write
    localparam axil_addr_t reg_root    = 5'h0C;  // read only
    localparam axil_addr_t reg_remnant = 5'h10;  // read only

    // reg_ctrl bits
    localparam int ctrl_start_bit = 0;
    localparam int ctrl_abort_bit = 1;

    // reg_status bits
    localparam int status_busy_bit  = 0;
    localparam int status_valid_bit = 1;

    // command controller states
    typedef enum logic [1:0] {
        idle,     // waiting for start
        run,      // unit enabled and iterating
        capture   // result latched, enable dropped
    } ctrl_state_t;

    // 2'b11 never reached

endpackage

// ==== design/sqrt_unit.sv ====
`timescale 1ns/1ps

// digit-by-digit integer square root
// one root bit per enabled cycle, msb first
module sqrt_unit #(
    parameter int root_width = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enable,   // held high for the whole calculation
    input  logic                    flush,    // kills the calculation in flight
    input  logic [2*root_width-1:0] src,      // radicand, sampled on the first cycle
    output logic [root_width-1:0]   root,
    output logic [root_width:0]     remnant,  // max is 2*root, needs the extra bit
    output logic                    done
);
    typedef logic [$clog2(root_width):0] count_t;    // must hold root_width itself
    typedef logic [2*root_width-1:0]     operand_t;
    typedef logic [root_width-1:0]       root_t;
    typedef logic [root_width:0]         rem_t;
    typedef logic [root_width+2:0]       trial_t;    // remainder with two new bits below

    count_t   counter_q;   // bits still to retire
    count_t   counter_d;
    operand_t shift_q;     // radicand, consumed two bits at a time from the top
    operand_t shift_d;
    root_t    root_q;
    root_t    root_d;
    rem_t     rem_q;       // partial remainder
    rem_t     rem_d;

    logic       first_iter;
    logic [1:0] pair;       // next two radicand bits
    trial_t     part_rem;
    trial_t     trial;
    trial_t     diff;
    logic       neg;        // trial did not fit

    assign first_iter = counter_q == count_t'(root_width);

    // no load cycle, first pair comes straight from src
    assign pair = first_iter ? src[2*root_width-1 -: 2] : shift_q[2*root_width-1 -: 2];

    always_comb begin
        part_rem = {rem_q, pair};
        trial    = trial_t'({root_q, 2'b01});  // 4*root + 1
        diff     = part_rem - trial;
        neg      = diff[root_width+2];         // sign of the subtraction
    end

    always_comb begin
        if (!enable || flush || counter_q == '0) begin
            // idle, flushed or one cycle past done
            counter_d = count_t'(root_width);
            shift_d   = '0;
            root_d    = '0;
            rem_d     = '0;
        end else begin
            counter_d = counter_q - count_t'(1);
            shift_d   = (first_iter ? src : shift_q) << 2;
            root_d    = {root_q[root_width-2:0], ~neg};            // new lsb
            rem_d     = neg ? part_rem[root_width:0] : diff[root_width:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            counter_q <= count_t'(root_width);
            shift_q   <= '0;
            root_q    <= '0;
            rem_q     <= '0;
        end else begin
            counter_q <= counter_d;
            shift_q   <= shift_d;
            root_q    <= root_d;
            rem_q     <= rem_d;
        end
    end

    assign root    = root_q;
    assign remnant = rem_q;
    assign done    = counter_q == '0;  // valid for exactly one cycle

    // counter only reaches zero through a run of enabled cycles
    done_needs_enable: assert property (
        @(posedge clk) disable iff (rst)
        $rose(done) |-> $past(enable && !flush)
    );

    // a reloaded unit starts from a clean root
    root_clear_at_load: assert property (
        @(posedge clk) disable iff (rst)
        counter_q == count_t'(root_width) |-> root_q == '0
    );

endmodule

// ==== design/sqrt_ctrl.sv ====
`timescale 1ns/1ps

// command sequencer around sqrt_unit
module sqrt_ctrl #(
    parameter int root_width = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,           // one-cycle pulse from the bus
    input  logic                    abort,           // one-cycle pulse from the bus
    input  sqrt_pkg::axil_data_t    operand,
    output logic                    busy,
    output logic                    result_valid,    // sticky until next start or abort
    output logic [root_width-1:0]   result_root,
    output logic [root_width:0]     result_remnant,
    output logic                    enable,
    output logic                    flush,
    output logic [2*root_width-1:0] src,
    input  logic                    done,
    input  logic [root_width-1:0]   root,
    input  logic [root_width:0]     remnant
);
    sqrt_pkg::ctrl_state_t state;
    sqrt_pkg::ctrl_state_t state_next;

    assign busy = state != sqrt_pkg::idle;

    // abort takes enable away in the same cycle
    assign enable = (state == sqrt_pkg::run) && !abort;
    assign flush  = busy && abort;
    assign src    = operand[2*root_width-1:0];  // upper bits unused below width 16

    always_comb begin
        state_next = state;
        case (state)
            sqrt_pkg::idle:    if (start) state_next = sqrt_pkg::run;  // start while busy dropped
            sqrt_pkg::run:     if (abort) state_next = sqrt_pkg::idle;
                               else if (done) state_next = sqrt_pkg::capture;
            sqrt_pkg::capture: state_next = sqrt_pkg::idle;
            default:           state_next = sqrt_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= sqrt_pkg::idle;
            result_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (state == sqrt_pkg::idle && start) begin
                result_valid <= 1'b0;        // old result goes stale
            end else if (busy && abort) begin
                result_valid <= 1'b0;
            end else if (state == sqrt_pkg::run && done) begin
                result_valid <= 1'b1;        // seen during capture
            end
        end
    end

    // unit clears itself right after done, so grab it now
    always_ff @(posedge clk) begin
        if (state == sqrt_pkg::run && done && !abort) begin
            result_root    <= root;
            result_remnant <= remnant;
        end
    end

    no_enable_with_flush: assert property (
        @(posedge clk) disable iff (rst)
        !(enable && flush)
    );

    // valid only comes up together with the capture state
    valid_after_capture: assert property (
        @(posedge clk) disable iff (rst)
        $rose(result_valid) |-> state == sqrt_pkg::capture && $past(state == sqrt_pkg::run && done)
    );

endmodule

// ==== design/axil_regs.sv ====
`timescale 1ns/1ps

// axi4-lite slave with the accelerator register map
module axil_regs #(
    parameter int root_width = 16
) (
    input  logic                  clk,
    input  logic                  rst,

    // write address / data / response
    input  logic                  s_axil_awvalid,
    output logic                  s_axil_awready,
    input  sqrt_pkg::axil_addr_t  s_axil_awaddr,
    input  logic                  s_axil_wvalid,
    output logic                  s_axil_wready,
    input  sqrt_pkg::axil_data_t  s_axil_wdata,
    output logic                  s_axil_bvalid,
    input  logic                  s_axil_bready,
    output sqrt_pkg::axil_resp_t  s_axil_bresp,

    // read address / data
    input  logic                  s_axil_arvalid,
    output logic                  s_axil_arready,
    input  sqrt_pkg::axil_addr_t  s_axil_araddr,
    output logic                  s_axil_rvalid,
    input  logic                  s_axil_rready,
    output sqrt_pkg::axil_data_t  s_axil_rdata,
    output sqrt_pkg::axil_resp_t  s_axil_rresp,

    // toward the controller
    output logic                  start,
    output logic                  abort,
    output sqrt_pkg::axil_data_t  operand,
    input  logic                  busy,
    input  logic                  result_valid,
    input  logic [root_width-1:0] result_root,
    input  logic [root_width:0]   result_remnant
);
    logic                 aw_rdy_q;   // shared aw/w ready pulse
    logic                 wr_en;      // write handshake this cycle
    logic                 ar_rdy_q;
    logic                 rd_en;      // read handshake this cycle
    sqrt_pkg::axil_data_t op_q;
    sqrt_pkg::axil_data_t rd_word;

    // exact match on the five word offsets
    function automatic logic addr_mapped(input sqrt_pkg::axil_addr_t addr);
        case (addr)
            sqrt_pkg::reg_ctrl,
            sqrt_pkg::reg_status,
            sqrt_pkg::reg_operand,
            sqrt_pkg::reg_root,
            sqrt_pkg::reg_remnant: return 1'b1;
            default:               return 1'b0;
        endcase
    endfunction

    assign s_axil_awready = aw_rdy_q;
    assign s_axil_wready  = aw_rdy_q;   // both channels taken together
    assign wr_en          = aw_rdy_q && s_axil_awvalid && s_axil_wvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_rdy_q      <= 1'b0;
            s_axil_bvalid <= 1'b0;
        end else begin
            // one-cycle pulse, blocked while a response is pending
            aw_rdy_q <= s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid && !aw_rdy_q;
            if (wr_en) begin
                s_axil_bvalid <= 1'b1;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            s_axil_bresp <= addr_mapped(s_axil_awaddr) ? sqrt_pkg::resp_okay
                                                       : sqrt_pkg::resp_slverr;
        end
    end

    // strobes ignored, whole word replaced
    always_ff @(posedge clk) begin
        if (wr_en && s_axil_awaddr == sqrt_pkg::reg_operand) begin
            op_q <= s_axil_wdata;
        end
    end

    assign operand = op_q;

    // command pulses straight off the handshake
    assign start = wr_en && s_axil_awaddr == sqrt_pkg::reg_ctrl
                   && s_axil_wdata[sqrt_pkg::ctrl_start_bit];
    assign abort = wr_en && s_axil_awaddr == sqrt_pkg::reg_ctrl
                   && s_axil_wdata[sqrt_pkg::ctrl_abort_bit];

    assign s_axil_arready = ar_rdy_q;
    assign rd_en          = ar_rdy_q && s_axil_arvalid;

    always_comb begin
        rd_word = '0;  // ctrl and unmapped read as zero
        case (s_axil_araddr)
            sqrt_pkg::reg_status: begin
                rd_word[sqrt_pkg::status_busy_bit]  = busy;
                rd_word[sqrt_pkg::status_valid_bit] = result_valid;
            end
            sqrt_pkg::reg_operand: rd_word = op_q;
            sqrt_pkg::reg_root:    rd_word = sqrt_pkg::axil_data_t'(result_root);
            sqrt_pkg::reg_remnant: rd_word = sqrt_pkg::axil_data_t'(result_remnant);
            default:               rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_rdy_q      <= 1'b0;
            s_axil_rvalid <= 1'b0;
        end else begin
            ar_rdy_q <= s_axil_arvalid && !s_axil_rvalid && !ar_rdy_q;
            if (rd_en) begin
                s_axil_rvalid <= 1'b1;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    // read payload held until rready
    always_ff @(posedge clk) begin
        if (rd_en) begin
            s_axil_rdata <= rd_word;
            s_axil_rresp <= addr_mapped(s_axil_araddr) ? sqrt_pkg::resp_okay
                                                       : sqrt_pkg::resp_slverr;
        end
    end

    b_hold_until_ready: assert property (
        @(posedge clk) disable iff (rst)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp)
    );

    r_hold_until_ready: assert property (
        @(posedge clk) disable iff (rst)
        s_axil_rvalid && !s_axil_rready |=>
            s_axil_rvalid && $stable(s_axil_rdata) && $stable(s_axil_rresp)
    );

endmodule

// ==== design/sqrt_accel_top.sv ====
`timescale 1ns/1ps

// square-root accelerator, bus slave + controller + iterative unit
module sqrt_accel_top #(
    parameter int root_width = 16  // 2..16, operand fits one bus word
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 s_axil_awvalid,
    output logic                 s_axil_awready,
    input  sqrt_pkg::axil_addr_t s_axil_awaddr,
    input  logic                 s_axil_wvalid,
    output logic                 s_axil_wready,
    input  sqrt_pkg::axil_data_t s_axil_wdata,
    output logic                 s_axil_bvalid,
    input  logic                 s_axil_bready,
    output sqrt_pkg::axil_resp_t s_axil_bresp,
    input  logic                 s_axil_arvalid,
    output logic                 s_axil_arready,
    input  sqrt_pkg::axil_addr_t s_axil_araddr,
    output logic                 s_axil_rvalid,
    input  logic                 s_axil_rready,
    output sqrt_pkg::axil_data_t s_axil_rdata,
    output sqrt_pkg::axil_resp_t s_axil_rresp
);
    // bus side
    logic                    start;
    logic                    abort;
    sqrt_pkg::axil_data_t    operand;
    logic                    busy;
    logic                    result_valid;
    logic [root_width-1:0]   result_root;
    logic [root_width:0]     result_remnant;

    // unit side
    logic                    enable;
    logic                    flush;
    logic [2*root_width-1:0] src;
    logic                    done;
    logic [root_width-1:0]   root;
    logic [root_width:0]     remnant;

    axil_regs #(.root_width(root_width)) axil_regs_inst (.*);

    sqrt_ctrl #(.root_width(root_width)) sqrt_ctrl_inst (
        .clk, .rst, .start, .abort, .operand, .busy, .result_valid,
        .result_root, .result_remnant, .enable, .flush, .src,
        .done, .root, .remnant
    );

    sqrt_unit #(.root_width(root_width)) sqrt_unit_inst (
        .clk, .rst, .enable, .flush, .src, .root, .remnant, .done
    );

endmodule

// ==== verification/axil_bus_tasks.svh ====
localparam int handshake_limit = 64;  // cycles before a channel counts as stuck

// flags the hang and parks this process for the watchdog
task automatic report_stall(input string what);
    $display("timeout: %s", what);
    stalled = 1'b1;
    forever @(posedge clk);
endtask

// one transfer per call with drives on the rising edge and samples on the falling edge
task automatic bus_write(input sqrt_pkg::axil_addr_t addr, input sqrt_pkg::axil_data_t data,
                         output sqrt_pkg::axil_resp_t resp);
    int waited;
    int delay;
    @(posedge clk);
    s_axil_awvalid <= 1'b1;
    s_axil_awaddr  <= addr;
    s_axil_wvalid  <= 1'b1;
    s_axil_wdata   <= data;
    waited = 0;
    @(negedge clk);
    while (!(s_axil_awready && s_axil_wready)) begin
        if (waited == handshake_limit) report_stall("write address and data never accepted");
        waited++;
        @(negedge clk);
    end
    @(posedge clk);               // handshake edge
    s_axil_awvalid <= 1'b0;
    s_axil_wvalid  <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (!s_axil_bvalid) begin
        if (waited == handshake_limit) report_stall("write response channel never answered");
        waited++;
        @(negedge clk);
    end
    resp  = s_axil_bresp;
    delay = int'($urandom_range(7, 0));   // hold bready low a while
    repeat (delay) @(posedge clk);
    @(posedge clk);
    s_axil_bready <= 1'b1;
    @(posedge clk);
    s_axil_bready <= 1'b0;
endtask

task automatic bus_read(input sqrt_pkg::axil_addr_t addr, output sqrt_pkg::axil_data_t data,
                        output sqrt_pkg::axil_resp_t resp);
    int waited;
    int delay;
    @(posedge clk);
    s_axil_arvalid <= 1'b1;
    s_axil_araddr  <= addr;
    waited = 0;
    @(negedge clk);
    while (!s_axil_arready) begin
        if (waited == handshake_limit) report_stall("read address never accepted");
        waited++;
        @(negedge clk);
    end
    @(posedge clk);
    s_axil_arvalid <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (!s_axil_rvalid) begin
        if (waited == handshake_limit) report_stall("read data channel never answered");
        waited++;
        @(negedge clk);
    end
    data  = s_axil_rdata;
    resp  = s_axil_rresp;
    delay = int'($urandom_range(7, 0));   // rready held low while the payload must not move
    repeat (delay) @(posedge clk);
    @(posedge clk);
    s_axil_rready <= 1'b1;
    @(posedge clk);
    s_axil_rready <= 1'b0;
endtask

// ==== verification/sqrt_accel_tb.sv ====
`timescale 1ns/1ps

// bus-level testbench for the square-root accelerator
module sqrt_accel_tb;
    localparam int root_width = 16;
    localparam int poll_limit = 50;   // status reads before giving up

    logic                 clk;
    logic                 rst;
    logic                 s_axil_awvalid;
    logic                 s_axil_awready;
    sqrt_pkg::axil_addr_t s_axil_awaddr;
    logic                 s_axil_wvalid;
    logic                 s_axil_wready;
    sqrt_pkg::axil_data_t s_axil_wdata;
    logic                 s_axil_bvalid;
    logic                 s_axil_bready;
    sqrt_pkg::axil_resp_t s_axil_bresp;
    logic                 s_axil_arvalid;
    logic                 s_axil_arready;
    sqrt_pkg::axil_addr_t s_axil_araddr;
    logic                 s_axil_rvalid;
    logic                 s_axil_rready;
    sqrt_pkg::axil_data_t s_axil_rdata;
    sqrt_pkg::axil_resp_t s_axil_rresp;

    int   errors    = 0;      // failed checks over all tests
    int   tests_ok  = 0;
    int   tests_bad = 0;
    logic stalled   = 1'b0;   // a handshake hung

    sqrt_accel_top #(.root_width(root_width)) sqrt_accel_top_inst (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;    // 100 ns period

    `include "axil_bus_tasks.svh"

    // reference root by msb first bitwise search
    function automatic logic [15:0] floor_sqrt(input logic [31:0] x);
        logic [15:0] r;
        logic [15:0] trial;
        r = '0;
        for (int b = 15; b >= 0; b--) begin
            trial    = r;
            trial[b] = 1'b1;
            if (32'(trial) * 32'(trial) <= x) r = trial;
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("FAILED %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    // second_start issues a start mid-run that the DUT must ignore
    task automatic start_and_check(input sqrt_pkg::axil_data_t op, input logic [31:0] exp_root,
                                   input logic [31:0] exp_rem, input logic second_start);
        sqrt_pkg::axil_resp_t resp;
        sqrt_pkg::axil_data_t data;
        int                   polls;
        logic                 busy_seen;
        bus_write(sqrt_pkg::reg_operand, op, resp);
        check_value("bresp", 32'(sqrt_pkg::resp_okay), 32'(resp));
        bus_write(sqrt_pkg::reg_ctrl, 32'h1, resp);
        if (second_start) bus_write(sqrt_pkg::reg_ctrl, 32'h1, resp);
        busy_seen = 1'b0;
        polls     = 0;
        bus_read(sqrt_pkg::reg_status, data, resp);
        while (!data[sqrt_pkg::status_valid_bit]) begin
            if (data[sqrt_pkg::status_busy_bit]) busy_seen = 1'b1;
            if (polls == poll_limit) report_stall("result_valid never came up in reg_status");
            polls++;
            bus_read(sqrt_pkg::reg_status, data, resp);
        end
        assert (busy_seen || second_start) else begin
            $display("busy was never seen while the calculation ran");
            errors++;
        end
        bus_read(sqrt_pkg::reg_root, data, resp);
        check_value("root", exp_root, data);
        bus_read(sqrt_pkg::reg_remnant, data, resp);
        check_value("remnant", exp_rem, data);
    endtask

    task automatic check_operand(input sqrt_pkg::axil_data_t op, input logic second_start);
        logic [15:0] r;
        r = floor_sqrt(op);
        start_and_check(op, 32'(r), op - 32'(r) * 32'(r), second_start);
    endtask

    task automatic check_unmapped(input sqrt_pkg::axil_addr_t addr);
        sqrt_pkg::axil_resp_t resp;
        sqrt_pkg::axil_data_t data;
        bus_write(addr, 32'hFFFF_FFFF, resp);
        check_value("bresp", 32'(sqrt_pkg::resp_slverr), 32'(resp));
        bus_read(addr, data, resp);
        check_value("rresp", 32'(sqrt_pkg::resp_slverr), 32'(resp));
        check_value("rdata", 32'h0, data);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d wrong check(s)", name, errors - errors_before);
        end
    endtask

    initial begin
        sqrt_pkg::axil_data_t data;
        sqrt_pkg::axil_data_t op;
        sqrt_pkg::axil_resp_t resp;
        int                   mark;
        void'($urandom(32'h18f6fd0d));
        rst = 1'b1;
        {s_axil_awvalid, s_axil_wvalid, s_axil_bready, s_axil_arvalid, s_axil_rready} = '0;
        s_axil_awaddr = '0;
        s_axil_araddr = '0;
        s_axil_wdata  = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        mark = errors;
        @(negedge clk);
        check_value("bvalid", 32'h0, 32'(s_axil_bvalid));
        check_value("rvalid", 32'h0, 32'(s_axil_rvalid));
        check_value("awready", 32'h0, 32'(s_axil_awready));
        check_value("wready", 32'h0, 32'(s_axil_wready));
        check_value("arready", 32'h0, 32'(s_axil_arready));
        bus_read(sqrt_pkg::reg_status, data, resp);
        check_value("status", 32'h0, data);
        check_value("rresp", 32'(sqrt_pkg::resp_okay), 32'(resp));
        finish_test("reset_state", mark);

        mark = errors;
        repeat (20) begin
            op = $urandom();
            check_operand(op, 1'b0);
        end
        finish_test("random_operands", mark);

        mark = errors;
        start_and_check(32'h0, 32'h0, 32'h0, 1'b0);
        start_and_check(32'h1, 32'h1, 32'h0, 1'b0);
        start_and_check(32'hFFFF_FFFF, 32'h0000_FFFF, 32'h0001_FFFE, 1'b0);  // 17-bit remnant
        finish_test("edge_operands", mark);

        mark = errors;
        bus_write(sqrt_pkg::reg_operand, 32'h0009_0000, resp);
        bus_write(sqrt_pkg::reg_ctrl, 32'h1, resp);
        bus_write(sqrt_pkg::reg_ctrl, 32'h2, resp);   // abort lands mid-run
        bus_read(sqrt_pkg::reg_status, data, resp);
        check_value("status", 32'h0, data);
        check_operand(32'h0012_3456, 1'b0);
        finish_test("abort", mark);

        mark = errors;
        check_unmapped(5'h14);
        check_unmapped(5'h1C);
        bus_write(sqrt_pkg::reg_root, 32'hDEAD_BEEF, resp);
        check_value("bresp", 32'(sqrt_pkg::resp_okay), 32'(resp));
        bus_read(sqrt_pkg::reg_root, data, resp);
        check_value("root", 32'(floor_sqrt(32'h0012_3456)), data);  // still from the abort test
        check_operand(32'hC0FF_EE00, 1'b1);
        finish_test("bus_errors", mark);

        mark = errors;
        repeat (5) begin
            op = $urandom();
            bus_write(sqrt_pkg::reg_operand, op, resp);
            bus_read(sqrt_pkg::reg_operand, data, resp);
            check_value("operand", op, data);
            check_operand(op, 1'b0);
        end
        finish_test("back_pressure", mark);

        $display("summary: %0d tests ok, %0d tests with errors, %0d failed checks",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // ends the run when a bus task hangs
    initial begin
        wait (stalled);
        $display("test failed");
        $finish;
    end

    bresp_held: assert property (
        @(posedge clk) disable iff (rst)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp)
    ) else begin
        $display("write response dropped or changed before bready");
        errors++;
    end

    rdata_held: assert property (
        @(posedge clk) disable iff (rst)
        s_axil_rvalid && !s_axil_rready |=>
            s_axil_rvalid && $stable(s_axil_rdata) && $stable(s_axil_rresp)
    ) else begin
        $display("read response dropped or changed before rready");
        errors++;
    end

    // 2'b11 is never a legal controller state
    state_legal: assert property (
        @(posedge clk) disable iff (rst)
        sqrt_accel_top_inst.sqrt_ctrl_inst.state inside
            {sqrt_pkg::idle, sqrt_pkg::run, sqrt_pkg::capture}
    ) else begin
        $display("controller state left its legal set");
        errors++;
    end

endmodule

// ==== flist.f ====
+incdir+verification
design/sqrt_pkg.sv
design/sqrt_unit.sv
design/sqrt_ctrl.sv
design/axil_regs.sv
design/sqrt_accel_top.sv
verification/sqrt_accel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the square-root accelerator testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    --top-module sqrt_accel_tb \
    -f flist.f

./obj_dir/Vsqrt_accel_tb > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
if grep -qx "test passed" sim.log; then
    exit 0
fi
echo "pass line missing from sim.log"
exit 1
